// File: Makefile
# Verilator flow for the SoC memory system

VERILATOR ?= verilator
FILELIST  ?= build.f
TB_TOP    ?= soc_tb
RTL_TOP   ?= soc_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
+incdir+hw
hw/soc_pkg.sv
hw/soc_addr_decoder.sv
hw/soc_bootrom.sv
hw/soc_l2_sram.sv
hw/soc_ctrl_regs.sv
hw/soc_apb_bridge.sv
hw/soc_top.sv
dv/soc_tb.sv

// File: dv/soc_tb.sv
// SoC memory system testbench
// Drives the master port, answers the UART APB port with random wait
// states and checks responses, control outputs and APB timing with
// concurrent assertions sampled on the falling clock edge

`include "soc_settings.svh"

module soc_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import soc_pkg::*;

  localparam int TIMEOUT = 20;

  logic          clk_i;
  logic          reset_i;
  soc_mem_req_t  bus_req;
  soc_mem_rsp_t  bus_rsp;
  soc_data_t     exit_out;
  soc_data_t     dram_base_out;
  soc_data_t     dram_end_out;
  soc_data_t     event_out;
  soc_data_t     cnt_en_out;
  soc_apb_req_t  uart_apb_req;
  soc_apb_rsp_t  uart_apb_rsp;

  int unsigned   errors;
  int unsigned   timeouts;
  logic [31:0]   rng_state;

  // Request being driven and response in flight
  string         req_name;
  logic          req_fast;
  string         rsp_name;
  soc_data_t     rsp_exp_d;
  logic          rsp_exp_e;
  logic          rsp_chk;

  // Reference models
  soc_data_t     exit_m;
  soc_data_t     event_m;
  soc_data_t     cnt_en_m;
  soc_data_t     l2_m [`SOC_L2_WORDS];

  // APB responder data and the transfer it should see
  soc_apb_data_t apb_rdata;
  logic          apb_slverr;
  soc_apb_addr_t apb_addr_exp;
  soc_apb_data_t apb_wdata_exp;
  logic          apb_write_exp;

  soc_top dut (
    .clk_i            ( clk_i         ),
    .reset_i          ( reset_i       ),
    .bus_req_i        ( bus_req       ),
    .bus_rsp_o        ( bus_rsp       ),
    .exit_o           ( exit_out      ),
    .dram_base_addr_o ( dram_base_out ),
    .dram_end_addr_o  ( dram_end_out  ),
    .event_trigger_o  ( event_out     ),
    .hw_cnt_en_o      ( cnt_en_out    ),
    .uart_apb_o       ( uart_apb_req  ),
    .uart_apb_i       ( uart_apb_rsp  )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // Signature plus index on top, inverted index below
  function automatic soc_data_t rom_expect(logic [7:0] idx);
    return {`SOC_ROM_SIGNATURE + {24'h0, idx}, ~{24'h0, idx}};
  endfunction

  function automatic soc_data_t merge_bytes(soc_data_t old_d, soc_data_t new_d, soc_be_t be);
    soc_data_t res;
    res = old_d;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_d[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic soc_data_t ctrl_expect(logic [11:0] ofs);
    case (ofs)
      `SOC_CTRL_EXIT_OFS:      return exit_m;
      `SOC_CTRL_DRAM_BASE_OFS: return 64'(`SOC_DRAM_BASE);
      `SOC_CTRL_DRAM_END_OFS:  return 64'(`SOC_DRAM_BASE) + 64'(`SOC_DRAM_LENGTH);
      `SOC_CTRL_EVENT_OFS:     return event_m;
      `SOC_CTRL_CNT_EN_OFS:    return cnt_en_m;
      default:                 return '0;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Master port tasks called on a rising edge
  //////////////////////////////////////////////////////////////////////

  task automatic issue_req(input logic we, input soc_addr_t addr, input soc_data_t wdata,
                           input soc_be_t be, input soc_data_t exp_d, input logic exp_e,
                           input logic chk, input string name);
    int n;
    bus_req  <= '{req: 1'b1, we: we, addr: addr, wdata: wdata, be: be};
    req_name = name;
    req_fast = (addr - `SOC_UART_BASE) >= `SOC_UART_LENGTH;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!bus_rsp.gnt && n < TIMEOUT);
    if (!bus_rsp.gnt) begin
      $display("Timeout waiting for a grant in %s", name);
      timeouts++;
    end
    @(posedge clk_i);
    // Expectation follows the grant into the response cycle
    rsp_name  = name;
    rsp_exp_d = exp_d;
    rsp_exp_e = exp_e;
    rsp_chk   = chk;
  endtask

  task automatic wait_rsp(input string name);
    int n;
    bus_req.req <= 1'b0;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!bus_rsp.rvalid && n < TIMEOUT);
    if (!bus_rsp.rvalid) begin
      $display("Timeout waiting for the response in %s", name);
      timeouts++;
    end
    @(posedge clk_i);
  endtask

  task automatic access(input logic we, input soc_addr_t addr, input soc_data_t wdata,
                        input soc_be_t be, input soc_data_t exp_d, input logic exp_e,
                        input logic chk, input string name);
    issue_req(we, addr, wdata, be, exp_d, exp_e, chk, name);
    wait_rsp(name);
  endtask

  task automatic ctrl_write(input logic [11:0] ofs, input soc_data_t wd, input soc_be_t be);
    issue_req(1'b1, `SOC_CTRL_BASE + 32'(ofs), wd, be, '0, 1'b0, 1'b0, "ctrl_write");
    // Model changes on the same edge as the registers
    case (ofs)
      `SOC_CTRL_EXIT_OFS:   exit_m   <= merge_bytes(exit_m, wd, be);
      `SOC_CTRL_EVENT_OFS:  event_m  <= merge_bytes(event_m, wd, be);
      `SOC_CTRL_CNT_EN_OFS: cnt_en_m <= merge_bytes(cnt_en_m, wd, be);
      default: ;
    endcase
    wait_rsp("ctrl_write");
  endtask

  task automatic uart_access(input logic we, input logic hi, input logic slverr,
                             input string name);
    soc_data_t wd;
    soc_addr_t addr;
    wd            = {next_rand(), next_rand()};
    addr          = `SOC_UART_BASE + (hi ? 32'h14 : 32'h10);
    apb_rdata     = next_rand();
    apb_slverr    = slverr;
    apb_addr_exp  = addr;
    apb_wdata_exp = hi ? wd[63:32] : wd[31:0];
    apb_write_exp = we;
    access(we, addr, wd, 8'hFF, hi ? {apb_rdata, 32'h0} : {32'h0, apb_rdata},
           slverr, !we, name);
  endtask

  // UART side answers after 0 to 3 wait states
  initial begin : apb_responder
    int unsigned wait_cyc;
    uart_apb_rsp = '0;
    forever begin
      @(negedge clk_i);
      if (uart_apb_req.psel && !uart_apb_req.penable) begin
        wait_cyc = next_rand() % 4;
        repeat (wait_cyc + 1) @(posedge clk_i);
        uart_apb_rsp <= '{prdata: apb_rdata, pready: 1'b1, pslverr: apb_slverr};
        @(posedge clk_i);
        uart_apb_rsp <= '0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  a_reset_low: assert property (@(negedge clk_i) $fell(reset_i) |->
      {bus_rsp.gnt, bus_rsp.rvalid, uart_apb_req.psel, uart_apb_req.penable,
       |exit_out, |event_out, |cnt_en_out} == 7'h0)
    else begin
      errors++;
      $display("ERROR reset_outputs expected %h actual %h", 7'h0,
               {bus_rsp.gnt, bus_rsp.rvalid, uart_apb_req.psel, uart_apb_req.penable,
                |exit_out, |event_out, |cnt_en_out});
    end

  a_dram_bounds: assert property (@(negedge clk_i) disable iff (reset_i)
      {dram_base_out, dram_end_out} ==
      {64'(`SOC_DRAM_BASE), 64'(`SOC_DRAM_BASE) + 64'(`SOC_DRAM_LENGTH)})
    else begin
      errors++;
      $display("ERROR dram_bounds expected %h %h actual %h %h", 64'(`SOC_DRAM_BASE),
               64'(`SOC_DRAM_BASE) + 64'(`SOC_DRAM_LENGTH), dram_base_out, dram_end_out);
    end

  a_gnt_now: assert property (@(negedge clk_i) disable iff (reset_i)
      bus_req.req && req_fast |-> bus_rsp.gnt)
    else begin
      errors++;
      $display("ERROR %s gnt expected 1 actual %b", req_name, bus_rsp.gnt);
    end

  a_rvalid_next: assert property (@(negedge clk_i) disable iff (reset_i)
      bus_rsp.gnt |=> bus_rsp.rvalid)
    else begin
      errors++;
      $display("ERROR %s rvalid expected 1 actual %b", rsp_name, bus_rsp.rvalid);
    end

  a_rvalid_only: assert property (@(negedge clk_i) disable iff (reset_i)
      bus_rsp.rvalid |-> $past(bus_rsp.gnt))
    else begin
      errors++;
      $display("Response valid without a grant in the cycle before");
    end

  a_rdata: assert property (@(negedge clk_i) disable iff (reset_i)
      bus_rsp.rvalid && rsp_chk |-> bus_rsp.rdata == rsp_exp_d)
    else begin
      errors++;
      $display("ERROR %s expected %h actual %h", rsp_name, rsp_exp_d, bus_rsp.rdata);
    end

  a_err: assert property (@(negedge clk_i) disable iff (reset_i)
      bus_rsp.rvalid |-> bus_rsp.err == rsp_exp_e)
    else begin
      errors++;
      $display("ERROR %s err expected %b actual %b", rsp_name, rsp_exp_e, bus_rsp.err);
    end

  a_ctrl_out: assert property (@(negedge clk_i) disable iff (reset_i)
      exit_out == exit_m && event_out == event_m && cnt_en_out == cnt_en_m)
    else begin
      errors++;
      $display("ERROR ctrl_outputs expected %h %h %h actual %h %h %h",
               exit_m, event_m, cnt_en_m, exit_out, event_out, cnt_en_out);
    end

  // APB phases
  a_apb_setup: assert property (@(negedge clk_i) disable iff (reset_i)
      uart_apb_req.psel && !uart_apb_req.penable |=> uart_apb_req.psel && uart_apb_req.penable)
    else begin
      errors++;
      $display("APB SETUP cycle was not followed by ACCESS");
    end

  a_apb_hold: assert property (@(negedge clk_i) disable iff (reset_i)
      uart_apb_req.penable && !uart_apb_rsp.pready |=> uart_apb_req.psel && uart_apb_req.penable)
    else begin
      errors++;
      $display("APB ACCESS ended before pready");
    end

  a_apb_end: assert property (@(negedge clk_i) disable iff (reset_i)
      uart_apb_req.penable && uart_apb_rsp.pready |=> !uart_apb_req.psel)
    else begin
      errors++;
      $display("APB psel still high after the transfer completed");
    end

  a_apb_addr: assert property (@(negedge clk_i) disable iff (reset_i)
      uart_apb_req.psel |-> uart_apb_req.paddr == apb_addr_exp)
    else begin
      errors++;
      $display("ERROR uart_paddr expected %h actual %h", apb_addr_exp, uart_apb_req.paddr);
    end

  a_apb_write: assert property (@(negedge clk_i) disable iff (reset_i)
      uart_apb_req.psel |-> uart_apb_req.pwrite == apb_write_exp)
    else begin
      errors++;
      $display("ERROR uart_pwrite expected %b actual %b", apb_write_exp, uart_apb_req.pwrite);
    end

  a_apb_wdata: assert property (@(negedge clk_i) disable iff (reset_i)
      uart_apb_req.psel && uart_apb_req.pwrite |-> uart_apb_req.pwdata == apb_wdata_exp)
    else begin
      errors++;
      $display("ERROR uart_pwdata expected %h actual %h", apb_wdata_exp, uart_apb_req.pwdata);
    end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    soc_data_t   wd;
    soc_be_t     be;
    soc_addr_t   alias_ofs;
    int unsigned idx;
    rng_state     = 32'd8;
    errors        = 0;
    timeouts      = 0;
    exit_m        = '0;
    event_m       = '0;
    cnt_en_m      = '0;
    apb_rdata     = '0;
    apb_slverr    = 1'b0;
    apb_addr_exp  = '0;
    apb_wdata_exp = '0;
    apb_write_exp = 1'b0;
    rsp_name      = "idle";
    rsp_exp_d     = '0;
    rsp_exp_e     = 1'b0;
    rsp_chk       = 1'b0;
    req_name      = "idle";
    req_fast      = 1'b0;
    bus_req       = '0;
    reset_i       = 1'b1;
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);

    // Boot ROM single reads then back to back reads
    for (int i = 0; i < 4; i++) begin
      idx = (i == 3) ? 255 : next_rand() % 256;
      access(1'b0, `SOC_BOOT_BASE + idx * 8, '0, 8'hFF, rom_expect(idx[7:0]), 1'b0, 1'b1,
             "rom_read");
    end
    for (int i = 0; i < 4; i++) begin
      issue_req(1'b0, `SOC_BOOT_BASE + 32'h100 + i * 8, '0, 8'hFF, rom_expect(8'(32 + i)),
                1'b0, 1'b1, "rom_back_to_back");
    end
    wait_rsp("rom_back_to_back");

    // L2 full words first so every model byte is known
    for (int i = 0; i < 8; i++) begin
      wd = {next_rand(), next_rand()};
      l2_m[i * 37] = wd;
      access(1'b1, `SOC_DRAM_BASE + i * 37 * 8, wd, 8'hFF, '0, 1'b0, 1'b0, "l2_write");
    end
    for (int i = 0; i < 8; i++) begin
      wd = {next_rand(), next_rand()};
      be = 8'(next_rand());
      l2_m[i * 37] = merge_bytes(l2_m[i * 37], wd, be);
      access(1'b1, `SOC_DRAM_BASE + i * 37 * 8, wd, be, '0, 1'b0, 1'b0, "l2_write_be");
    end
    for (int i = 0; i < 8; i++) begin
      // Odd words are read back through an aliased address
      alias_ofs = (i % 2 == 1) ? 32'h0100_0000 : 32'h0;
      access(1'b0, `SOC_DRAM_BASE + alias_ofs + i * 37 * 8, '0, 8'hFF, l2_m[i * 37],
             1'b0, 1'b1, "l2_read");
    end

    // Control registers
    ctrl_write(`SOC_CTRL_EXIT_OFS, {next_rand(), next_rand()}, 8'h0F);
    ctrl_write(`SOC_CTRL_EXIT_OFS, {next_rand(), next_rand()}, 8'hC0);
    ctrl_write(`SOC_CTRL_EVENT_OFS, {next_rand(), next_rand()}, 8'hFF);
    ctrl_write(`SOC_CTRL_CNT_EN_OFS, {next_rand(), next_rand()}, 8'h01);
    ctrl_write(`SOC_CTRL_DRAM_BASE_OFS, {next_rand(), next_rand()}, 8'hFF);
    ctrl_write(`SOC_CTRL_DRAM_END_OFS, {next_rand(), next_rand()}, 8'hFF);
    ctrl_write(12'h028, {next_rand(), next_rand()}, 8'hFF);
    for (int ofs = 0; ofs <= 'h30; ofs += 8) begin
      access(1'b0, `SOC_CTRL_BASE + 32'(ofs), '0, 8'hFF, ctrl_expect(12'(ofs)), 1'b0, 1'b1,
             "ctrl_read");
    end
    access(1'b0, `SOC_CTRL_BASE + 32'hFF8, '0, 8'hFF, '0, 1'b0, 1'b1, "ctrl_read_empty");

    // UART through the APB bridge
    uart_access(1'b1, 1'b0, 1'b0, "uart_write_lo");
    uart_access(1'b1, 1'b1, 1'b0, "uart_write_hi");
    uart_access(1'b0, 1'b0, 1'b0, "uart_read_lo");
    uart_access(1'b0, 1'b1, 1'b0, "uart_read_hi");
    uart_access(1'b0, 1'b1, 1'b1, "uart_read_slverr");
    uart_access(1'b1, 1'b0, 1'b1, "uart_write_slverr");

    // Former debug region is unmapped
    access(1'b0, 32'h0000_1000, '0, 8'hFF, '0, 1'b1, 1'b1, "unmapped_read");
    access(1'b1, 32'h0000_1008, {next_rand(), next_rand()}, 8'hFF, '0, 1'b1, 1'b0,
           "unmapped_write");

    repeat (2) @(posedge clk_i);
    $display("Checks done with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: hw/soc_addr_decoder.sv
// SoC address decoder
// Routes each master request to boot ROM, L2, control registers or
// the UART bridge, grants it and returns the response one cycle later.
// Unmapped addresses are granted at once and answered with an error

`include "soc_settings.svh"

module soc_addr_decoder (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  soc_pkg::soc_mem_req_t bus_req_i,
  output soc_pkg::soc_mem_rsp_t bus_rsp_o,
  output soc_pkg::soc_mem_req_t rom_req_o,
  output soc_pkg::soc_mem_req_t l2_req_o,
  output soc_pkg::soc_mem_req_t ctrl_req_o,
  output soc_pkg::soc_mem_req_t uart_req_o,
  input  soc_pkg::soc_data_t    rom_rdata_i,
  input  soc_pkg::soc_data_t    l2_rdata_i,
  input  soc_pkg::soc_data_t    ctrl_rdata_i,
  input  soc_pkg::soc_data_t    uart_rdata_i,
  input  logic                  uart_gnt_i,
  input  logic                  uart_err_i
);
  import soc_pkg::*;

  soc_target_e sel_tgt;
  soc_target_e tgt_q;
  logic        bus_gnt;
  logic        rvalid_q;

  // Wrapping subtraction gives a single unsigned range check
  function automatic logic in_region(soc_addr_t addr, soc_addr_t base, soc_addr_t len);
    return (addr - base) < len;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Request routing
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (in_region(bus_req_i.addr, `SOC_BOOT_BASE, `SOC_BOOT_LENGTH)) begin
      sel_tgt = TGT_ROM;
    end else if (in_region(bus_req_i.addr, `SOC_DRAM_BASE, `SOC_DRAM_LENGTH)) begin
      sel_tgt = TGT_L2;
    end else if (in_region(bus_req_i.addr, `SOC_CTRL_BASE, `SOC_CTRL_LENGTH)) begin
      sel_tgt = TGT_CTRL;
    end else if (in_region(bus_req_i.addr, `SOC_UART_BASE, `SOC_UART_LENGTH)) begin
      sel_tgt = TGT_UART;
    end else begin
      sel_tgt = TGT_NONE;
    end
  end

  always_comb begin
    rom_req_o      = bus_req_i;
    l2_req_o       = bus_req_i;
    ctrl_req_o     = bus_req_i;
    uart_req_o     = bus_req_i;
    rom_req_o.req  = bus_req_i.req && (sel_tgt == TGT_ROM);
    l2_req_o.req   = bus_req_i.req && (sel_tgt == TGT_L2);
    ctrl_req_o.req = bus_req_i.req && (sel_tgt == TGT_CTRL);
    uart_req_o.req = bus_req_i.req && (sel_tgt == TGT_UART);
  end

  // Only the UART path can stall
  assign bus_gnt = bus_req_i.req && ((sel_tgt != TGT_UART) || uart_gnt_i);

  //////////////////////////////////////////////////////////////////////
  // Response path
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
      tgt_q    <= TGT_NONE;
    end else begin
      rvalid_q <= bus_gnt;
      if (bus_gnt) begin
        tgt_q <= sel_tgt;
      end
    end
  end

  always_comb begin
    bus_rsp_o.gnt    = bus_gnt;
    bus_rsp_o.rvalid = rvalid_q;
    bus_rsp_o.rdata  = '0;
    bus_rsp_o.err    = 1'b0;
    case (tgt_q)
      TGT_ROM:  bus_rsp_o.rdata = rom_rdata_i;
      TGT_L2:   bus_rsp_o.rdata = l2_rdata_i;
      TGT_CTRL: bus_rsp_o.rdata = ctrl_rdata_i;
      TGT_UART: begin
        bus_rsp_o.rdata = uart_rdata_i;
        bus_rsp_o.err   = rvalid_q && uart_err_i;
      end
      // Unmapped, zero data
      default:  bus_rsp_o.err = rvalid_q;
    endcase
  end

  a_one_target: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0({rom_req_o.req, l2_req_o.req, ctrl_req_o.req, uart_req_o.req}))
    else $error("more than one target selected");

  a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
    bus_rsp_o.rvalid |-> $past(bus_rsp_o.gnt))
    else $error("rvalid without a grant in the previous cycle");

endmodule

// File: hw/soc_apb_bridge.sv
// UART APB bridge
// Turns one 64-bit memory access into a 32-bit APB transfer,
// selecting the word half from address bit 2

module soc_apb_bridge (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  soc_pkg::soc_mem_req_t req_i,
  output logic                  gnt_o,
  output soc_pkg::soc_data_t    rdata_o,
  output logic                  err_o,
  output soc_pkg::soc_apb_req_t apb_o,
  input  soc_pkg::soc_apb_rsp_t apb_i
);
  import soc_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } apb_state_e;

  apb_state_e state_q;
  apb_state_e state_d;
  logic       hi_half;

  assign hi_half = req_i.addr[2];

  // Grant as soon as the slave completes
  assign gnt_o = (state_q == ST_ACCESS) && apb_i.pready;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:   if (req_i.req) state_d = ST_SETUP;
      ST_SETUP:  state_d = ST_ACCESS;
      ST_ACCESS: if (apb_i.pready) state_d = ST_IDLE;
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    apb_o.psel    = (state_q != ST_IDLE);
    apb_o.penable = (state_q == ST_ACCESS);
    apb_o.pwrite  = req_i.we;
    apb_o.paddr   = soc_apb_addr_t'(req_i.addr);
    apb_o.pwdata  = hi_half ? req_i.wdata[63:32] : req_i.wdata[31:0];
  end

  // Response held until the next transfer completes
  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      rdata_o <= hi_half ? {apb_i.prdata, 32'h0} : {32'h0, apb_i.prdata};
      err_o   <= apb_i.pslverr;
    end
  end

  a_access_after_setup: assert property (@(posedge clk_i) disable iff (reset_i)
    apb_o.penable |-> apb_o.psel && $past(apb_o.psel))
    else $error("penable without psel or without a setup cycle");

endmodule

// File: hw/soc_bootrom.sv
// Boot ROM
// Read-only memory with a rule-based word pattern and a
// one-cycle read latency, writes have no effect

`include "soc_settings.svh"

module soc_bootrom (
  input  logic                  clk_i,
  input  soc_pkg::soc_mem_req_t req_i,
  output soc_pkg::soc_data_t    rdata_o
);
  import soc_pkg::*;

  localparam int unsigned ROM_AW = $clog2(`SOC_ROM_WORDS);

  logic [ROM_AW-1:0] word_idx;
  soc_data_t         rom_word;

  assign word_idx = req_i.addr[ROM_AW+2:3];

  // Signature plus index on top, inverted index below
  assign rom_word = {`SOC_ROM_SIGNATURE + 32'(word_idx), ~32'(word_idx)};

  always_ff @(posedge clk_i) begin
    if (req_i.req && !req_i.we) begin
      rdata_o <= rom_word;
    end
  end

endmodule

// File: hw/soc_ctrl_regs.sv
// Control registers
// Exit code, DRAM window bounds, event trigger and hardware counter
// enable, with byte-enabled writes and a registered read mux

`include "soc_settings.svh"

module soc_ctrl_regs (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  soc_pkg::soc_mem_req_t req_i,
  output soc_pkg::soc_data_t    rdata_o,
  output soc_pkg::soc_data_t    exit_o,
  output soc_pkg::soc_data_t    dram_base_addr_o,
  output soc_pkg::soc_data_t    dram_end_addr_o,
  output soc_pkg::soc_data_t    event_trigger_o,
  output soc_pkg::soc_data_t    hw_cnt_en_o
);
  import soc_pkg::*;

  localparam soc_data_t DRAM_BASE = 64'(`SOC_DRAM_BASE);
  localparam soc_data_t DRAM_END  = 64'(`SOC_DRAM_BASE) + 64'(`SOC_DRAM_LENGTH);

  soc_data_t   exit_q;
  soc_data_t   event_q;
  soc_data_t   cnt_en_q;
  soc_data_t   rd_word;
  logic [11:0] word_ofs;
  logic        wr_en;

  function automatic soc_data_t be_merge(soc_data_t old_d, soc_data_t new_d, soc_be_t be);
    soc_data_t res;
    res = old_d;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_d[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Registers are 64-bit aligned
  assign word_ofs = {req_i.addr[11:3], 3'b000};
  assign wr_en    = req_i.req && req_i.we;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_q   <= '0;
      event_q  <= '0;
      cnt_en_q <= '0;
    end else if (wr_en) begin
      case (word_ofs)
        `SOC_CTRL_EXIT_OFS:   exit_q   <= be_merge(exit_q, req_i.wdata, req_i.be);
        `SOC_CTRL_EVENT_OFS:  event_q  <= be_merge(event_q, req_i.wdata, req_i.be);
        `SOC_CTRL_CNT_EN_OFS: cnt_en_q <= be_merge(cnt_en_q, req_i.wdata, req_i.be);
        default: ;
      endcase
    end
  end

  always_comb begin
    case (word_ofs)
      `SOC_CTRL_EXIT_OFS:      rd_word = exit_q;
      `SOC_CTRL_DRAM_BASE_OFS: rd_word = DRAM_BASE;
      `SOC_CTRL_DRAM_END_OFS:  rd_word = DRAM_END;
      `SOC_CTRL_EVENT_OFS:     rd_word = event_q;
      `SOC_CTRL_CNT_EN_OFS:    rd_word = cnt_en_q;
      default:                 rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req && !req_i.we) begin
      rdata_o <= rd_word;
    end
  end

  assign exit_o           = exit_q;
  assign dram_base_addr_o = DRAM_BASE;
  assign dram_end_addr_o  = DRAM_END;
  assign event_trigger_o  = event_q;
  assign hw_cnt_en_o      = cnt_en_q;

endmodule

// File: hw/soc_l2_sram.sv
// L2 memory
// Single-port 64-bit SRAM with byte-enabled writes and registered
// reads, the DRAM window aliases onto its depth

`include "soc_settings.svh"

module soc_l2_sram (
  input  logic                  clk_i,
  input  soc_pkg::soc_mem_req_t req_i,
  output soc_pkg::soc_data_t    rdata_o
);
  import soc_pkg::*;

  localparam int unsigned L2_AW = $clog2(`SOC_L2_WORDS);

  soc_data_t        mem_q [`SOC_L2_WORDS];
  logic [L2_AW-1:0] word_idx;

  // Upper address bits are ignored
  assign word_idx = req_i.addr[L2_AW+2:3];

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        for (int b = 0; b < 8; b++) begin
          if (req_i.be[b]) begin
            mem_q[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[word_idx];
      end
    end
  end

endmodule

// File: hw/soc_pkg.sv
// SoC package
// Bus widths, decoded target encoding and the packed
// request and response bundles of the memory and APB ports

package soc_pkg;

  typedef logic [31:0] soc_addr_t;
  typedef logic [63:0] soc_data_t;
  typedef logic [7:0]  soc_be_t;
  typedef logic [31:0] soc_apb_addr_t;
  typedef logic [31:0] soc_apb_data_t;

  typedef enum logic [2:0] {
    TGT_ROM,
    TGT_L2,
    TGT_CTRL,
    TGT_UART,
    TGT_NONE
  } soc_target_e;

  // Memory-style request, held by the master until gnt
  typedef struct packed {
    logic      req;
    logic      we;
    soc_addr_t addr;
    soc_data_t wdata;
    soc_be_t   be;
  } soc_mem_req_t;

  typedef struct packed {
    logic      gnt;
    logic      rvalid;
    soc_data_t rdata;
    logic      err;
  } soc_mem_rsp_t;

  typedef struct packed {
    logic          psel;
    logic          penable;
    logic          pwrite;
    soc_apb_addr_t paddr;
    soc_apb_data_t pwdata;
  } soc_apb_req_t;

  typedef struct packed {
    soc_apb_data_t prdata;
    logic          pready;
    logic          pslverr;
  } soc_apb_rsp_t;

endpackage

// File: hw/soc_settings.svh
// SoC settings
// Memory map, memory depths, boot ROM signature and the
// control register offsets shared by the RTL and the testbench

`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// Memory map
`define SOC_BOOT_BASE   32'h0005_0000
`define SOC_BOOT_LENGTH 32'h0001_0000
`define SOC_DRAM_BASE   32'h8000_0000
`define SOC_DRAM_LENGTH 32'h4000_0000
`define SOC_UART_BASE   32'hC000_0000
`define SOC_UART_LENGTH 32'h0000_1000
`define SOC_CTRL_BASE   32'hD000_0000
`define SOC_CTRL_LENGTH 32'h0000_1000

// Memory depths in 64-bit words
`define SOC_ROM_WORDS 256
`define SOC_L2_WORDS  1024

`define SOC_ROM_SIGNATURE 32'hB007_0000

// Control register byte offsets
`define SOC_CTRL_EXIT_OFS      12'h000
`define SOC_CTRL_DRAM_BASE_OFS 12'h008
`define SOC_CTRL_DRAM_END_OFS  12'h010
`define SOC_CTRL_EVENT_OFS     12'h018
`define SOC_CTRL_CNT_EN_OFS    12'h020

`endif

// File: hw/soc_top.sv
// SoC memory system top
// One memory-style master port decoded onto boot ROM, L2 memory,
// control registers and the UART APB bridge

module soc_top (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  soc_pkg::soc_mem_req_t bus_req_i,
  output soc_pkg::soc_mem_rsp_t bus_rsp_o,
  output soc_pkg::soc_data_t    exit_o,
  output soc_pkg::soc_data_t    dram_base_addr_o,
  output soc_pkg::soc_data_t    dram_end_addr_o,
  output soc_pkg::soc_data_t    event_trigger_o,
  output soc_pkg::soc_data_t    hw_cnt_en_o,
  output soc_pkg::soc_apb_req_t uart_apb_o,
  input  soc_pkg::soc_apb_rsp_t uart_apb_i
);
  import soc_pkg::*;

  soc_mem_req_t rom_req;
  soc_mem_req_t l2_req;
  soc_mem_req_t ctrl_req;
  soc_mem_req_t uart_req;
  soc_data_t    rom_rdata;
  soc_data_t    l2_rdata;
  soc_data_t    ctrl_rdata;
  soc_data_t    uart_rdata;
  logic         uart_gnt;
  logic         uart_err;

  //////////////////////////////////////////////////////////////////////
  // Decoder
  //////////////////////////////////////////////////////////////////////

  soc_addr_decoder i_addr_decoder (
    .clk_i        ( clk_i      ),
    .reset_i      ( reset_i    ),
    .bus_req_i    ( bus_req_i  ),
    .bus_rsp_o    ( bus_rsp_o  ),
    .rom_req_o    ( rom_req    ),
    .l2_req_o     ( l2_req     ),
    .ctrl_req_o   ( ctrl_req   ),
    .uart_req_o   ( uart_req   ),
    .rom_rdata_i  ( rom_rdata  ),
    .l2_rdata_i   ( l2_rdata   ),
    .ctrl_rdata_i ( ctrl_rdata ),
    .uart_rdata_i ( uart_rdata ),
    .uart_gnt_i   ( uart_gnt   ),
    .uart_err_i   ( uart_err   )
  );

  //////////////////////////////////////////////////////////////////////
  // Targets
  //////////////////////////////////////////////////////////////////////

  soc_bootrom i_bootrom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .rdata_o ( rom_rdata )
  );

  soc_l2_sram i_l2_sram (
    .clk_i   ( clk_i    ),
    .req_i   ( l2_req   ),
    .rdata_o ( l2_rdata )
  );

  soc_ctrl_regs i_ctrl_regs (
    .clk_i            ( clk_i            ),
    .reset_i          ( reset_i          ),
    .req_i            ( ctrl_req         ),
    .rdata_o          ( ctrl_rdata       ),
    .exit_o           ( exit_o           ),
    .dram_base_addr_o ( dram_base_addr_o ),
    .dram_end_addr_o  ( dram_end_addr_o  ),
    .event_trigger_o  ( event_trigger_o  ),
    .hw_cnt_en_o      ( hw_cnt_en_o      )
  );

  soc_apb_bridge i_uart_bridge (
    .clk_i   ( clk_i      ),
    .reset_i ( reset_i    ),
    .req_i   ( uart_req   ),
    .gnt_o   ( uart_gnt   ),
    .rdata_o ( uart_rdata ),
    .err_o   ( uart_err   ),
    .apb_o   ( uart_apb_o ),
    .apb_i   ( uart_apb_i )
  );

endmodule
